// ==== build.f ====
+incdir+src
src/bg_video_pkg.sv
src/bg_cpu_pkg.sv
src/bg_layer_if.sv
src/bg_cpu_if.sv
src/scroll_calc.sv
src/bg_layer.sv
src/layer_mixer.sv
src/bg_board_top.sv
test/bg_board_properties.sv
test/bg_board_tb.sv

// ==== Makefile ====
# Verilator build and run of the background board testbench
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := bg_board_tb
FILELIST  := build.f
LOG       := sim.log
FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run and check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "test passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== test/bg_board_tb.sv ====
// testbench with clock, reset, ROM model, CPU stimulus, checks, watchdog and summary
`timescale 1ns/1ps
`include "bg_cfg.svh"

module bg_board_tb;
   import bg_video_pkg::*;
   import bg_cpu_pkg::*;

   localparam int CLK_NS     = 100;
   localparam int UNIT_SCROLL = 0;
   localparam int UNIT_PAL    = `BG_NUM_LAYERS + 1;  // maps are units 1 to 3
   // reset, readback, tile fetch, mixing, blanking
   localparam int TEST_CYCLES = 4 + 172 + 1590 + 320 + 11;
   localparam int WATCHDOG_NS = TEST_CYCLES * CLK_NS * 3 / 2;

   logic       grpclk1;
   logic       rst_n_i;
   logic       pix_en_i;
   logic       blank_n_i;
   hpos_t      hpos_i;
   vpos_t      vpos_i;
   logic       flip_i;
   cpu_addr_t  cpu_addr_i;
   cpu_data_t  cpu_data_i;
   logic       cpu_wr_i;
   logic       cpu_rd_i;
   logic       cs_scroll_i;
   logic [`BG_NUM_LAYERS-1:0] cs_map_i;
   logic       cs_pal_i;
   pixel_t     obj_pix_i;
   rom_addr_t  layer_rom_addr_o [`BG_NUM_LAYERS];
   plane_row_t layer_rom_data_i [`BG_NUM_LAYERS][3];  // ROM model, constant per test step
   cpu_data_t  cpu_data_o;
   rgb_t       rgb_o;

   cpu_data_t  scroll_sh [8];
   tile_code_t map_sh [`BG_NUM_LAYERS][`BG_MAP_DEPTH];
   pal_entry_t pal_sh [`BG_PAL_DEPTH];
   int         errors;
   int         test_errors;
   int         tests_failed;
   int         tests_run;
   int         prop_failures;

   bg_board_top dut_i (.*);

   bind bg_board_top bg_board_properties u_props (
      .grpclk1    (grpclk1),
      .rst_n_i    (rst_n_i),
      .pix_en_i   (pix_en_i),
      .cpu_rd_i   (cpu_rd_i),
      .rdata_i    (cpu_data_o),
      .rgb_i      (rgb_o),
      .rom_addr_i (layer_rom_addr_o)
   );

   initial begin
      grpclk1 = 1'b0;
      forever #(CLK_NS / 2) grpclk1 = ~grpclk1;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("watchdog expired before all tests completed");
      $display("Simulation finished: FAIL");
      $finish;
   end

   // ==============================
   // helpers
   // ==============================

   task automatic step(input int n);
      repeat (n) begin
         @(posedge grpclk1);
         #5;
      end
   endtask

   task automatic compare_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
      assert (got === exp)
      else begin
         $display("error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic select_unit(input int unit);
      cs_scroll_i = (unit == UNIT_SCROLL);
      cs_pal_i    = (unit == UNIT_PAL);
      cs_map_i    = '0;
      if (unit >= 1 && unit <= `BG_NUM_LAYERS)
         cs_map_i[unit - 1] = 1'b1;
   endtask

   task automatic cpu_write(input int unit, input int addr, input cpu_data_t data);
      select_unit(unit);
      cpu_addr_i = cpu_addr_t'(addr);
      cpu_data_i = data;
      cpu_wr_i   = 1'b1;
      if (unit == UNIT_SCROLL)
         scroll_sh[addr[2:0]] = data;
      else if (unit == UNIT_PAL)
         pal_sh[addr[4:0]] = data;
      else
         map_sh[unit - 1][addr[8:0]] = data;
      step(1);
      cpu_wr_i = 1'b0;
      select_unit(-1);
   endtask

   // data is due in the cycle after the strobe
   task automatic cpu_read(input int unit, input int addr);
      cpu_data_t exp;
      select_unit(unit);
      cpu_addr_i = cpu_addr_t'(addr);
      cpu_rd_i   = 1'b1;
      step(1);
      if (unit == UNIT_SCROLL)
         exp = scroll_sh[addr[2:0]];
      else if (unit == UNIT_PAL)
         exp = pal_sh[addr[4:0]];
      else
         exp = map_sh[unit - 1][addr[8:0]];
      compare_value("cpu read data", 32'(cpu_data_o), 32'(exp));
      cpu_rd_i = 1'b0;
      select_unit(-1);
   endtask

   // i1 i0 b3 b2 g3 g2 r3 r2, output is R G B
   function automatic rgb_t expand_entry(input pal_entry_t e);
      logic [3:0] ch [3];
      for (int c = 0; c < 3; c++) begin
         if (e[2 * c +: 2] == 2'b00)
            ch[c] = 4'h0;
         else
            ch[c] = {e[2 * c +: 2], e[7:6]};
      end
      return {ch[0], ch[1], ch[2]};
   endfunction

   function automatic pal_index_t pick_index(input pixel_t obj, input pixel_t l0,
                                             input pixel_t l1, input pixel_t l2);
      if (obj != 3'd0)
         return {2'd3, obj};
      if (l0 != 3'd0)
         return {2'd2, l0};
      if (l1 != 3'd0)
         return {2'd1, l1};
      return {2'd0, l2};  // zero when every source is clear
   endfunction

   task automatic finish_test(input string name);
      // concurrent assertion failures belong to the test that was running
      errors += dut_i.u_props.fail_count - prop_failures;
      prop_failures = dut_i.u_props.fail_count;
      tests_run++;
      if (errors != test_errors)
         tests_failed++;
      $display("test %0d %s: %s", tests_run, name, (errors == test_errors) ? "ok" : "failed");
      test_errors = errors;
   endtask

   // ==============================
   // tests
   // ==============================

   initial begin
      int         ra;
      vpos_t      vp;
      row_t       sum;
      tile_code_t codes [`BG_NUM_LAYERS];
      pixel_t     lp [`BG_NUM_LAYERS];
      void'($urandom(32'h25f8_95de));
      rst_n_i    = 1'b0;
      pix_en_i   = 1'b1;
      blank_n_i  = 1'b1;
      hpos_i     = 9'd1;  // nonzero, no line start
      vpos_i     = '0;
      flip_i     = 1'b0;
      cpu_addr_i = '0;
      cpu_data_i = '0;
      cpu_wr_i   = 1'b0;
      cpu_rd_i   = 1'b0;
      obj_pix_i  = '0;
      select_unit(-1);
      for (int l = 0; l < `BG_NUM_LAYERS; l++)
         for (int p = 0; p < 3; p++)
            layer_rom_data_i[l][p] = '0;
      errors        = 0;
      test_errors   = 0;
      tests_failed  = 0;
      tests_run     = 0;
      prop_failures = 0;
      repeat (2) @(posedge grpclk1);
      #5;
      rst_n_i = 1'b1;

      compare_value("rgb after reset", 32'(rgb_o), 0);
      compare_value("read data after reset", 32'(cpu_data_o), 0);
      for (int l = 0; l < `BG_NUM_LAYERS; l++)
         compare_value("ROM address after reset", 32'(layer_rom_addr_o[l]), 0);
      step(1);
      finish_test("reset values");

      for (int a = 0; a < 2 * `BG_NUM_LAYERS; a++) begin
         cpu_write(UNIT_SCROLL, a, cpu_data_t'($urandom));
         cpu_read(UNIT_SCROLL, a);
      end
      for (int i = 0; i < 16 * `BG_NUM_LAYERS; i++) begin
         ra = $urandom_range(`BG_MAP_DEPTH - 1, 0);
         cpu_write(1 + i % `BG_NUM_LAYERS, ra, cpu_data_t'($urandom));
         cpu_read(1 + i % `BG_NUM_LAYERS, ra);
      end
      for (int a = 0; a < `BG_PAL_DEPTH; a++) begin
         cpu_write(UNIT_PAL, a, cpu_data_t'($urandom));
         cpu_read(UNIT_PAL, a);
      end
      finish_test("CPU readback");

      for (int l = 0; l < `BG_NUM_LAYERS; l++) begin
         codes[l] = tile_code_t'($urandom);
         for (int a = 0; a < `BG_MAP_DEPTH; a++)
            cpu_write(1 + l, a, codes[l]);
      end
      for (int f = 0; f < 2; f++) begin
         flip_i = f[0];
         for (int l = 0; l < `BG_NUM_LAYERS; l++) begin
            cpu_write(UNIT_SCROLL, 2 * l, cpu_data_t'($urandom));      // vertical
            cpu_write(UNIT_SCROLL, 2 * l + 1, cpu_data_t'($urandom));  // horizontal
         end
         vp     = vpos_t'($urandom);
         vpos_i = vp;
         hpos_i = '0;
         step(1);
         hpos_i = 9'd1;
         step(20);
         for (int l = 0; l < `BG_NUM_LAYERS; l++) begin
            sum = {1'b0, scroll_sh[2 * l]} + {1'b0, vp};
            compare_value("ROM address tile code", 32'(layer_rom_addr_o[l][12:5]),
                          32'(codes[l]));
            compare_value("ROM address row bits",
                          32'({layer_rom_addr_o[l][4], layer_rom_addr_o[l][2:0]}),
                          32'(sum[3:0]));
         end
      end
      finish_test("tile fetch address");

      for (int s = 0; s < 16; s++) begin
         flip_i = s[0];
         for (int l = 0; l < `BG_NUM_LAYERS; l++) begin
            for (int p = 0; p < 3; p++) begin
               lp[l][p] = 1'($urandom);
               layer_rom_data_i[l][p] = lp[l][p] ? 8'hff : 8'h00;
            end
         end
         obj_pix_i = pixel_t'($urandom);
         step(20);  // shifters reload, then two mixer stages
         compare_value("mixed colour", 32'(rgb_o),
                       32'(expand_entry(pal_sh[pick_index(obj_pix_i, lp[0], lp[1], lp[2])])));
      end
      finish_test("priority mixing");

      pix_en_i = 1'b0;
      step(4);
      pix_en_i  = 1'b1;
      blank_n_i = 1'b0;
      step(3);
      compare_value("blanked colour", 32'(rgb_o), 32'(expand_entry(pal_sh[0])));
      obj_pix_i = 3'd7;
      step(4);
      compare_value("blanked colour with object", 32'(rgb_o), 32'(expand_entry(pal_sh[0])));
      blank_n_i = 1'b1;
      finish_test("blanking");

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

// ==== test/bg_board_properties.sv ====
// concurrent checks of reset values, idle read data, pixel hold and colour expansion
`timescale 1ns/1ps
`include "bg_cfg.svh"

module bg_board_properties (
   input logic                    grpclk1,
   input logic                    rst_n_i,
   input logic                    pix_en_i,
   input logic                    cpu_rd_i,
   input bg_cpu_pkg::cpu_data_t   rdata_i,
   input bg_video_pkg::rgb_t      rgb_i,
   input bg_video_pkg::rom_addr_t rom_addr_i [`BG_NUM_LAYERS]
);

   int fail_count = 0;  // failed assertions so far

   // ==============================
   // reset and CPU read data
   // ==============================

   // first edge after release still samples the reset values
   a_reset_out : assert property (@(posedge grpclk1)
      $rose(rst_n_i) |-> (rgb_i == '0 && rdata_i == '0))
      else begin
         $error("rgb or read data not zero after reset");
         fail_count++;
      end

   a_rdata_idle : assert property (@(posedge grpclk1) disable iff (!rst_n_i)
      !$past(cpu_rd_i) |-> rdata_i == '0)
      else begin
         $error("read data not zero without a read strobe");
         fail_count++;
      end

   a_rgb_hold : assert property (@(posedge grpclk1) disable iff (!rst_n_i)
      !pix_en_i |=> $stable(rgb_i))
      else begin
         $error("rgb changed while pixel enable was low");
         fail_count++;
      end

   // ==============================
   // per layer and per channel
   // ==============================

   for (genvar g = 0; g < `BG_NUM_LAYERS; g++) begin : g_layer
      a_rom_reset : assert property (@(posedge grpclk1)
         $rose(rst_n_i) |-> rom_addr_i[g] == '0)
         else begin
            $error("layer ROM address not zero after reset");
            fail_count++;
         end

      a_rom_hold : assert property (@(posedge grpclk1) disable iff (!rst_n_i)
         !pix_en_i |=> $stable(rom_addr_i[g]))
         else begin
            $error("layer ROM address changed while pixel enable was low");
            fail_count++;
         end
   end

   for (genvar c = 0; c < 3; c++) begin : g_chan
      // black channel carries no intensity
      a_chan_black : assert property (@(posedge grpclk1)
         rgb_i[4 * c + 3 -: 2] == 2'b00 |-> rgb_i[4 * c + 1 -: 2] == 2'b00)
         else begin
            $error("colour channel has intensity bits but no colour bits");
            fail_count++;
         end
   end

endmodule

// ==== src/bg_board_top.sv ====
// background board top with scroll unit, three layer engines and mixer
`timescale 1ns/1ps
`include "bg_cfg.svh"

module bg_board_top (
   input  logic                     grpclk1,
   input  logic                     rst_n_i,
   input  logic                     pix_en_i,
   input  logic                     blank_n_i,
   input  bg_video_pkg::hpos_t      hpos_i,
   input  bg_video_pkg::vpos_t      vpos_i,
   input  logic                     flip_i,
   input  bg_cpu_pkg::cpu_addr_t    cpu_addr_i,
   input  bg_cpu_pkg::cpu_data_t    cpu_data_i,
   input  logic                     cpu_wr_i,
   input  logic                     cpu_rd_i,
   input  logic                     cs_scroll_i,
   input  logic [`BG_NUM_LAYERS-1:0] cs_map_i,
   input  logic                     cs_pal_i,
   input  bg_video_pkg::pixel_t     obj_pix_i,
   output bg_video_pkg::rom_addr_t  layer_rom_addr_o [`BG_NUM_LAYERS],
   input  bg_video_pkg::plane_row_t layer_rom_data_i [`BG_NUM_LAYERS]
                                                     [$bits(bg_video_pkg::pixel_t)],
   output bg_cpu_pkg::cpu_data_t    cpu_data_o,
   output bg_video_pkg::rgb_t       rgb_o
);
   import bg_cpu_pkg::*;

   cpu_data_t scroll_rdata;
   cpu_data_t map_rdata [`BG_NUM_LAYERS];
   cpu_data_t pal_rdata;

   bg_cpu_if   cpu_bus ();
   bg_layer_if lyr_bus [`BG_NUM_LAYERS] ();

   assign cpu_bus.addr  = cpu_addr_i;
   assign cpu_bus.wdata = cpu_data_i;
   assign cpu_bus.wr    = cpu_wr_i;
   assign cpu_bus.rd    = cpu_rd_i;

   scroll_calc u_scroll (
      .grpclk1   (grpclk1),
      .rst_n_i   (rst_n_i),
      .pix_en_i  (pix_en_i),
      .blank_n_i (blank_n_i),
      .hpos_i    (hpos_i),
      .vpos_i    (vpos_i),
      .sel_i     (cs_scroll_i),
      .cpu       (cpu_bus),
      .rdata_o   (scroll_rdata),
      .lyr       (lyr_bus)
   );

   for (genvar g = 0; g < `BG_NUM_LAYERS; g++) begin : g_layer
      bg_layer u_layer (
         .grpclk1      (grpclk1),
         .rst_n_i      (rst_n_i),
         .flip_i       (flip_i),
         .lyr          (lyr_bus[g]),
         .cpu          (cpu_bus),
         .sel_i        (cs_map_i[g]),
         .rdata_o      (map_rdata[g]),
         .rom_addr_o   (layer_rom_addr_o[g]),
         .rom_planes_i (layer_rom_data_i[g])
      );
   end

   layer_mixer u_mixer (
      .grpclk1   (grpclk1),
      .rst_n_i   (rst_n_i),
      .lyr       (lyr_bus),
      .obj_pix_i (obj_pix_i),
      .cpu       (cpu_bus),
      .sel_i     (cs_pal_i),
      .rdata_o   (pal_rdata),
      .rgb_o     (rgb_o)
   );

   // idle units return zero so the read data can be ORed
   always_comb begin
      cpu_data_o = scroll_rdata | pal_rdata;
      for (int i = 0; i < `BG_NUM_LAYERS; i++)
         cpu_data_o = cpu_data_o | map_rdata[i];
   end

endmodule

// ==== src/layer_mixer.sv ====
// priority mixer, palette RAM and RGB expansion
`timescale 1ns/1ps
`include "bg_cfg.svh"

module layer_mixer (
   input  logic                  grpclk1,
   input  logic                  rst_n_i,
   bg_layer_if.drain             lyr [`BG_NUM_LAYERS],
   input  bg_video_pkg::pixel_t  obj_pix_i,
   bg_cpu_if.target              cpu,
   input  logic                  sel_i,
   output bg_cpu_pkg::cpu_data_t rdata_o,
   output bg_video_pkg::rgb_t    rgb_o
);
   import bg_video_pkg::*;

   pixel_t     lay_pix [`BG_NUM_LAYERS];
   pal_entry_t palette [`BG_PAL_DEPTH];
   pal_index_t idx_next;
   pal_index_t idx_q;     // also the palette address register
   pal_entry_t pal_q;
   logic       rd_q;
   logic       pix_en;
   logic       blank_n;

   // two colour bits above the intensity pair, black when both are clear
   function automatic logic [3:0] expand_ch(input logic [1:0] ch, input logic [1:0] inten);
      return (ch == 2'b00) ? 4'h0 : {ch, inten};
   endfunction

   for (genvar g = 0; g < `BG_NUM_LAYERS; g++) begin : g_pix
      assign lay_pix[g] = lyr[g].pixel;
   end

   assign pix_en  = lyr[0].pix_en;
   assign blank_n = lyr[0].blank_n;

   // ==============================
   // priority select
   // ==============================

   always_comb begin
      idx_next = '0;
      // lowest priority first, later hits override
      for (int i = `BG_NUM_LAYERS - 1; i >= 0; i--) begin
         if (lay_pix[i] != '0)
            idx_next = {2'(`BG_NUM_LAYERS - 1 - i), lay_pix[i]};
      end
      if (obj_pix_i != '0)
         idx_next = {2'd3, obj_pix_i};
      if (!blank_n)
         idx_next = '0;
   end

   // ==============================
   // palette and output
   // ==============================

   always_ff @(posedge grpclk1) begin
      if (sel_i && cpu.wr)
         palette[cpu.addr[4:0]] <= cpu.wdata;
   end

   assign pal_q   = palette[idx_q];
   assign rdata_o = rd_q ? pal_q : '0;

   always_ff @(posedge grpclk1 or negedge rst_n_i) begin
      if (!rst_n_i) begin
         idx_q <= '0;
         rd_q  <= 1'b0;
         rgb_o <= '0;
      end else begin
         rd_q <= sel_i && cpu.rd;
         if (sel_i)
            idx_q <= cpu.addr[4:0];  // CPU access
         else if (pix_en)
            idx_q <= idx_next;
         if (pix_en) begin
            rgb_o <= {expand_ch(pal_q[1:0], pal_q[7:6]),
                      expand_ch(pal_q[3:2], pal_q[7:6]),
                      expand_ch(pal_q[5:4], pal_q[7:6])};
         end
      end
   end

endmodule

// ==== src/bg_layer.sv ====
// layer engine with tile map RAM, ROM address fetch and plane shifters
`timescale 1ns/1ps
`include "bg_cfg.svh"

module bg_layer (
   input  logic                     grpclk1,
   input  logic                     rst_n_i,
   input  logic                     flip_i,
   bg_layer_if.layer                lyr,
   bg_cpu_if.target                 cpu,
   input  logic                     sel_i,
   output bg_cpu_pkg::cpu_data_t    rdata_o,
   output bg_video_pkg::rom_addr_t  rom_addr_o,
   input  bg_video_pkg::plane_row_t rom_planes_i [$bits(bg_video_pkg::pixel_t)]
);
   import bg_video_pkg::*;

   tile_code_t tile_map [`BG_MAP_DEPTH];
   tile_code_t map_q;
   map_addr_t  map_addr;
   logic       map_rd_en;
   logic       rd_q;
   xpos_t      cnt_q;
   logic [2:0] phase;
   plane_row_t shift_q [$bits(pixel_t)];

   assign phase = cnt_q[2:0];

   // ==============================
   // pixel counter
   // ==============================

   always_ff @(posedge grpclk1 or negedge rst_n_i) begin
      if (!rst_n_i) begin
         cnt_q <= '0;
      end else if (lyr.line_start) begin
         cnt_q <= lyr.hscroll;
      end else if (lyr.pix_en && lyr.blank_n) begin
         cnt_q <= cnt_q + 1'b1;
      end
   end

   // ==============================
   // tile map
   // ==============================

   // CPU owns the map while selected
   assign map_addr  = sel_i ? cpu.addr : {lyr.row[8:4], cnt_q[7:4]};
   assign map_rd_en = sel_i ? cpu.rd : (lyr.pix_en && phase == `BG_PH_MAP);

   always_ff @(posedge grpclk1) begin
      if (sel_i && cpu.wr)
         tile_map[cpu.addr] <= cpu.wdata;
      if (map_rd_en)
         map_q <= tile_map[map_addr];
   end

   always_ff @(posedge grpclk1 or negedge rst_n_i) begin
      if (!rst_n_i)
         rd_q <= 1'b0;
      else
         rd_q <= sel_i && cpu.rd;
   end

   assign rdata_o = rd_q ? map_q : '0;

   // ==============================
   // ROM address and shifters
   // ==============================

   always_ff @(posedge grpclk1 or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rom_addr_o <= '0;
      end else if (lyr.pix_en && phase == `BG_PH_ADDR) begin
         // code, row[3], half tile, line in tile
         rom_addr_o <= {map_q, lyr.row[3], cnt_q[3] ^ flip_i, lyr.row[2:0]};
      end
   end

   always_ff @(posedge grpclk1 or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int p = 0; p < $bits(pixel_t); p++)
            shift_q[p] <= '0;
      end else if (lyr.pix_en) begin
         for (int p = 0; p < $bits(pixel_t); p++) begin
            if (phase == `BG_PH_LOAD)
               shift_q[p] <= rom_planes_i[p];  // ROM data is combinational
            else if (flip_i)
               shift_q[p] <= {1'b0, shift_q[p][7:1]};
            else
               shift_q[p] <= {shift_q[p][6:0], 1'b0};
         end
      end
   end

   // flipped screen reads from the LSB end
   always_comb begin
      for (int p = 0; p < $bits(pixel_t); p++)
         lyr.pixel[p] = flip_i ? shift_q[p][0] : shift_q[p][7];
   end

endmodule

// ==== src/scroll_calc.sv ====
// scroll registers, line start detection and per-layer row computation
`timescale 1ns/1ps
`include "bg_cfg.svh"

module scroll_calc (
   input  logic                  grpclk1,
   input  logic                  rst_n_i,
   input  logic                  pix_en_i,
   input  logic                  blank_n_i,
   input  bg_video_pkg::hpos_t   hpos_i,
   input  bg_video_pkg::vpos_t   vpos_i,
   input  logic                  sel_i,
   bg_cpu_if.target              cpu,
   output bg_cpu_pkg::cpu_data_t rdata_o,
   bg_layer_if.feeder            lyr [`BG_NUM_LAYERS]
);
   import bg_video_pkg::*;
   import bg_cpu_pkg::*;

   vpos_t     vscroll_q [`BG_NUM_LAYERS];
   xpos_t     hscroll_q [`BG_NUM_LAYERS];
   row_t      row_q [`BG_NUM_LAYERS];
   logic      line_start_q;
   logic      lsel_ok;
   cpu_data_t rd_mux;

   // addr[2:1] picks the layer, addr[0] the horizontal byte
   assign lsel_ok = (cpu.addr[2:1] < `BG_NUM_LAYERS);

   always_comb begin
      rd_mux = '0;
      if (lsel_ok)
         rd_mux = cpu.addr[0] ? hscroll_q[cpu.addr[2:1]] : vscroll_q[cpu.addr[2:1]];
   end

   always_ff @(posedge grpclk1 or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `BG_NUM_LAYERS; i++) begin
            vscroll_q[i] <= '0;
            hscroll_q[i] <= '0;
            row_q[i]     <= '0;
         end
         line_start_q <= 1'b0;
         rdata_o      <= '0;
      end else begin
         if (sel_i && cpu.wr && lsel_ok) begin
            if (cpu.addr[0])
               hscroll_q[cpu.addr[2:1]] <= cpu.wdata;
            else
               vscroll_q[cpu.addr[2:1]] <= cpu.wdata;
         end
         rdata_o <= (sel_i && cpu.rd) ? rd_mux : '0;

         // one pulse at the start of each line
         line_start_q <= pix_en_i && (hpos_i == '0);
         if (pix_en_i && (hpos_i == '0)) begin
            for (int i = 0; i < `BG_NUM_LAYERS; i++)
               row_q[i] <= row_t'(vscroll_q[i]) + row_t'(vpos_i);  // carry into bit 8
         end
      end
   end

   for (genvar g = 0; g < `BG_NUM_LAYERS; g++) begin : g_feed
      assign lyr[g].row        = row_q[g];
      assign lyr[g].hscroll    = hscroll_q[g];
      assign lyr[g].line_start = line_start_q;
      assign lyr[g].pix_en     = pix_en_i;
      assign lyr[g].blank_n    = blank_n_i;
   end

endmodule

// ==== src/bg_cpu_if.sv ====
// interface for the shared CPU address, write data and strobes
`timescale 1ns/1ps

interface bg_cpu_if;
   import bg_cpu_pkg::*;

   cpu_addr_t addr;
   cpu_data_t wdata;
   logic      wr;   // write strobe
   logic      rd;   // read strobe

   // every unit decodes its own select
   modport target (
      input addr,
      input wdata,
      input wr,
      input rd
   );

endinterface

// ==== src/bg_layer_if.sv ====
// interface for scroll, timing and pixel between scroll unit, layers and mixer
`timescale 1ns/1ps

interface bg_layer_if;
   import bg_video_pkg::*;

   row_t   row;        // scrolled line of this layer
   xpos_t  hscroll;
   logic   line_start;
   logic   pix_en;
   logic   blank_n;
   pixel_t pixel;      // shifter output

   modport feeder (
      output row,
      output hscroll,
      output line_start,
      output pix_en,
      output blank_n
   );

   modport layer (
      input  row,
      input  hscroll,
      input  line_start,
      input  pix_en,
      input  blank_n,
      output pixel
   );

   // mixer only needs timing of the first layer
   modport drain (
      input pixel,
      input pix_en,
      input blank_n
   );

endinterface

// ==== src/bg_cpu_pkg.sv ====
// CPU bus address and data types
package bg_cpu_pkg;

   // shared address, wide enough for one tile map
   typedef logic [8:0] cpu_addr_t;

   typedef logic [7:0] cpu_data_t;

endpackage

// ==== src/bg_video_pkg.sv ====
// pixel, tile, address and colour types of the background video path
package bg_video_pkg;

   // one pixel, one bit from each plane
   typedef logic [2:0] pixel_t;

   typedef logic [7:0] tile_code_t;  // map entry
   typedef logic [8:0] map_addr_t;
   typedef logic [12:0] rom_addr_t;  // graphics ROM
   typedef logic [7:0] plane_row_t;

   // scrolled line, carry kept
   typedef logic [8:0] row_t;

   typedef logic [7:0] xpos_t;  // layer pixel counter
   typedef logic [8:0] hpos_t;
   typedef logic [7:0] vpos_t;

   // ==============================
   // palette and colour
   // ==============================

   typedef logic [4:0] pal_index_t;
   typedef logic [7:0] pal_entry_t;
   typedef logic [11:0] rgb_t;  // R, G, B nibbles

endpackage

// ==== src/bg_cfg.svh ====
// layer count, RAM depth and fetch phase macros
`ifndef BG_CFG_SVH
`define BG_CFG_SVH

// ==============================
// layer structure
// ==============================

`define BG_NUM_LAYERS 3

// tile map entries per layer
`define BG_MAP_DEPTH 512

// palette entries shared by all sources
`define BG_PAL_DEPTH 32

// ==============================
// fetch phases
// ==============================

// low three bits of the layer pixel counter
`define BG_PH_MAP  3'd3
`define BG_PH_ADDR 3'd5
`define BG_PH_LOAD 3'd7

`endif
